// File: ext_playground.f
common/playground_bus_pkg.sv
common/playground_cfg_pkg.sv
rtl/periph_bridge.sv
system_timer/system_timer.sv
dma/dma_regs.sv
dma/dma_mover.sv
rtl/ext_playground.sv
testbench/ext_playground_props.sv
testbench/tb_ext_playground.sv

// File: Bender.yml
package:
  name: ext_playground

sources:
  # Packages first, then the blocks, then the top level
  - common/playground_bus_pkg.sv
  - common/playground_cfg_pkg.sv
  - rtl/periph_bridge.sv
  - system_timer/system_timer.sv
  - dma/dma_regs.sv
  - dma/dma_mover.sv
  - rtl/ext_playground.sv
  - target: test
    files:
      - testbench/ext_playground_props.sv
      - testbench/tb_ext_playground.sv

// File: testbench/tb_ext_playground.sv
/*
 * Testbench for the accelerator playground
 * Random timer, bridge and DMA traffic checked against models kept here,
 * with a sparse memory and random latency behind each DMA master port.
 */
`timescale 1ns/1ps

module tb_ext_playground;
  import playground_bus_pkg::*;
  import playground_cfg_pkg::*;

  logic                      clk;
  logic                      rst;
  logic                      rtc;
  wide_req_t                 periph_req;
  wide_rsp_t                 periph_rsp;
  wide_req_t [NumDsaDma-1:0] cfg_req;
  wide_rsp_t [NumDsaDma-1:0] cfg_rsp;
  wide_req_t [NumDsaDma-1:0] mem_req;
  wide_rsp_t [NumDsaDma-1:0] mem_rsp;

  integer seed = 32'hc27651a0;
  int     checks = 0;
  int     errors = 0;
  int     err_mark = 0;

  // Sparse memory, keyed by engine index over byte address
  data_t                mem [logic [63:0]];
  logic [NumDsaDma-1:0] pend;
  int unsigned          wait_left [NumDsaDma];
  wide_req_t            pend_req [NumDsaDma];
  logic [NumDsaDma-1:0] user_seen = '0;

  // Timer and DMA register models
  logic        tmr_en = 1'b0;
  logic [63:0] tmr_cnt = '0;
  addr_t       reg_src [NumDsaDma];
  addr_t       reg_dst [NumDsaDma];
  len_t        reg_len [NumDsaDma];
  data_t       exp_words [NumDsaDma][8];

  ext_playground dut_i (
    .clk_i         ( clk        ),
    .reset_i       ( rst        ),
    .rtc_i         ( rtc        ),
    .periph_req_i  ( periph_req ),
    .periph_rsp_o  ( periph_rsp ),
    .dma_cfg_req_i ( cfg_req    ),
    .dma_cfg_rsp_o ( cfg_rsp    ),
    .dma_mem_req_o ( mem_req    ),
    .dma_mem_rsp_i ( mem_rsp    )
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  //////////////////////////////////////////////////
  // Helpers
  //////////////////////////////////////////////////

  function automatic int unsigned rand_below(input int unsigned n);
    return $unsigned($random(seed)) % n;
  endfunction

  function automatic data_t rand_word();
    return {$random(seed), $random(seed)};
  endfunction

  function automatic data_t mem_read(input int p, input addr_t addr);
    logic [63:0] key;
    key = {16'(p), addr};
    if (mem.exists(key)) begin
      return mem[key];
    end
    // Untouched locations return an address-derived pattern
    return {addr[15:0], addr} ^ 64'h5a5a_5a5a_5a5a_5a5a;
  endfunction

  task automatic check_value(input logic [63:0] got, input logic [63:0] exp,
                             input string what);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("[FAIL] %0t ns: %s, got %h, expected %h", $time, what, got, exp);
    end
  endtask

  task automatic abort_on_timeout(input string what);
    $display("Timeout while waiting for %s", what);
    $display("Errors found");
    $finish;
  endtask

  task automatic report_test(input string name);
    if (errors == err_mark) begin
      $display("%-20s passed", name);
    end else begin
      $display("%-20s failed with %0d mismatches", name, errors - err_mark);
    end
    err_mark = errors;
  endtask

  task automatic periph_access(input logic we, input addr_t addr, input data_t wdata,
                               input strb_t strb, output data_t rdata, output logic err);
    int cycles;
    periph_req = '{valid: 1'b1, we: we, addr: addr, wdata: wdata, strb: strb, user: '0};
    @(negedge clk);
    periph_req = '0;
    cycles = 1;
    while (!periph_rsp.valid) begin
      if (cycles >= 10) begin
        abort_on_timeout("a peripheral response");
      end
      @(negedge clk);
      cycles++;
    end
    check_value(cycles, 2, "peripheral response latency");
    rdata = periph_rsp.rdata;
    err   = periph_rsp.err;
  endtask

  task automatic cfg_access(input int e, input logic we, input reg_off_t off,
                            input data_t wdata, output data_t rdata, output logic err);
    int cycles;
    cfg_req[e] = '{valid: 1'b1, we: we, addr: addr_t'(off), wdata: wdata, strb: '1, user: '0};
    @(negedge clk);
    cfg_req[e] = '0;
    cycles = 0;
    while (!cfg_rsp[e].valid) begin
      if (cycles >= 10) begin
        abort_on_timeout("a DMA configuration response");
      end
      @(negedge clk);
      cycles++;
    end
    check_value(cycles, 0, "config response later than one cycle");
    rdata = cfg_rsp[e].rdata;
    err   = cfg_rsp[e].err;
  endtask

  task automatic cfg_write(input int e, input reg_off_t off, input data_t wdata);
    data_t rd;
    logic  err;
    cfg_access(e, 1'b1, off, wdata, rd, err);
    check_value(err, 0, "config write error flag");
  endtask

  task automatic cfg_read(input int e, input reg_off_t off, output data_t rdata);
    logic err;
    cfg_access(e, 1'b0, off, '0, rdata, err);
    check_value(err, 0, "config read error flag");
  endtask

  task automatic timer_ctrl(input logic [31:0] value);
    data_t rd;
    logic  err;
    periph_access(1'b1, addr_t'(TimerBase + TimerCtrlOff), data_t'(value), '1, rd, err);
    check_value(err, 0, "timer CTRL write error flag");
    tmr_en = value[0];
    if (value[1]) begin
      tmr_cnt = '0;
    end
  endtask

  // CNT_LO sits in the upper lane, CNT_HI in the lower one
  task automatic timer_count(output logic [63:0] cnt);
    data_t lo;
    data_t hi;
    logic  err;
    periph_access(1'b0, addr_t'(TimerBase + TimerCntLoOff), '0, '0, lo, err);
    check_value(err, 0, "timer CNT_LO error flag");
    periph_access(1'b0, addr_t'(TimerBase + TimerCntHiOff), '0, '0, hi, err);
    check_value(err, 0, "timer CNT_HI error flag");
    cnt = {hi[31:0], lo[63:32]};
  endtask

  task automatic rtc_edges(input int n);
    for (int k = 0; k < n; k++) begin
      rtc = 1'b1;
      repeat (8) @(negedge clk);
      rtc = 1'b0;
      repeat (8) @(negedge clk);
    end
    if (tmr_en) begin
      tmr_cnt = tmr_cnt + 64'(n);
    end
  endtask

  function automatic addr_t pick_addr(input int e, input int region);
    return (addr_t'(e) << 40) | (addr_t'(region) << 32) | (addr_t'(rand_below(1 << 20)) << 3);
  endfunction

  // Fills the source words and programs the engine
  task automatic dma_setup(input int e, input addr_t src, input addr_t dst, input len_t len);
    for (int k = 0; k < len; k++) begin
      exp_words[e][k] = rand_word();
      mem[{16'(e), src + addr_t'(8 * k)}] = exp_words[e][k];
    end
    cfg_write(e, DmaSrcOff, data_t'(src));
    cfg_write(e, DmaDstOff, data_t'(dst));
    cfg_write(e, DmaLenOff, data_t'(len));
    reg_src[e] = src;
    reg_dst[e] = dst;
    reg_len[e] = len;
  endtask

  task automatic wait_dma_done(input int e);
    data_t status;
    int    polls;
    status = '0;
    polls  = 0;
    while (!status[1]) begin
      if (polls >= 200) begin
        abort_on_timeout("DMA completion");
      end
      cfg_read(e, DmaStatusOff, status);
      polls++;
    end
    check_value(status, 64'h2, "STATUS after copy");
  endtask

  task automatic check_copy(input int e, input addr_t dst, input len_t len);
    for (int k = 0; k < len; k++) begin
      check_value(mem_read(e, dst + addr_t'(8 * k)), exp_words[e][k], "copied word");
    end
  endtask

  //////////////////////////////////////////////////
  // Memory responder, one request in flight per port
  //////////////////////////////////////////////////

  initial begin
    mem_rsp = '0;
    pend    = '0;
    forever begin
      @(negedge clk);
      for (int p = 0; p < NumDsaDma; p++) begin
        mem_rsp[p] = '0;
        if (pend[p]) begin
          wait_left[p] = wait_left[p] - 1;
          if (wait_left[p] == 0) begin
            pend[p] = 1'b0;
            mem_rsp[p].valid = 1'b1;
            if (pend_req[p].we) begin
              mem[{16'(p), pend_req[p].addr}] = pend_req[p].wdata;
            end else begin
              mem_rsp[p].rdata = mem_read(p, pend_req[p].addr);
            end
          end
        end
        if (!rst && mem_req[p].valid) begin
          check_value(mem_req[p].strb, 8'hff, "memory request byte enables");
          check_value(mem_req[p].user, p, "memory request user tag");
          user_seen[p] = 1'b1;
          pend[p]      = 1'b1;
          pend_req[p]  = mem_req[p];
          wait_left[p] = 1 + rand_below(4);
        end
      end
    end
  end

  //////////////////////////////////////////////////
  // Tests
  //////////////////////////////////////////////////

  task automatic test_reset();
    logic [63:0] cnt;
    data_t       status;
    check_value(periph_rsp.valid, 0, "peripheral response valid after reset");
    for (int e = 0; e < NumDsaDma; e++) begin
      check_value(cfg_rsp[e].valid, 0, "config response valid after reset");
      check_value(mem_req[e].valid, 0, "memory request valid after reset");
    end
    timer_count(cnt);
    check_value(cnt, 0, "timer count after reset");
    for (int e = 0; e < NumDsaDma; e++) begin
      cfg_read(e, DmaStatusOff, status);
      check_value(status, 0, "STATUS after reset");
    end
    report_test("reset");
  endtask

  task automatic test_timer();
    logic [63:0] cnt;
    timer_ctrl(32'h1);
    rtc_edges(1 + rand_below(6));
    timer_count(cnt);
    check_value(cnt, tmr_cnt, "timer count while enabled");
    timer_ctrl(32'h0);
    rtc_edges(1 + rand_below(4));
    timer_count(cnt);
    check_value(cnt, tmr_cnt, "timer count after disable");
    timer_ctrl(32'h2);
    timer_count(cnt);
    check_value(cnt, 0, "timer count after clear");
    report_test("timer");
  endtask

  // One request per cycle, each answer checked exactly two cycles later
  task automatic test_bridge();
    data_t       exp_rd [$];
    logic        exp_err [$];
    int          n;
    int          kind;
    logic        we;
    logic        hit;
    logic        err;
    addr_t       addr;
    data_t       wdata;
    strb_t       strb;
    logic [31:0] d;
    // Nonzero count so the upper lane carries data too
    timer_ctrl(32'h1);
    rtc_edges(1 + rand_below(4));
    n = 12 + rand_below(8);
    for (int i = 0; i < n + 2; i++) begin
      if (i >= 2) begin
        check_value(periph_rsp.valid, 1, "bridge response valid");
        check_value(periph_rsp.rdata, exp_rd.pop_front(), "bridge read data");
        check_value(periph_rsp.err, exp_err.pop_front(), "bridge error flag");
      end
      if (i < n) begin
        kind  = rand_below(5);
        we    = (rand_below(2) == 1);
        wdata = rand_word();
        strb  = strb_t'(rand_below(256));
        hit   = (kind < 4);
        addr[47:32] = 16'(rand_below(65536));
        addr[31:0]  = hit ? TimerBase + 32'(4 * kind)
                          : 32'h8000_0000 | (rand_below(32'h1000_0000) & 32'hffff_fffc);
        d   = '0;
        err = 1'b1;
        if (hit) begin
          err = (kind == 3);
          case (kind)
            0:       d = 32'(tmr_en);
            1:       d = tmr_cnt[31:0];
            2:       d = tmr_cnt[63:32];
            default: d = '0;
          endcase
          if (we && kind == 0 && strb[0]) begin
            tmr_en = wdata[0];
            if (wdata[1]) begin
              tmr_cnt = '0;
            end
          end
        end
        if (we || err) begin
          d = '0;
        end
        exp_rd.push_back(addr[2] ? {d, 32'h0} : {32'h0, d});
        exp_err.push_back(err);
        periph_req = '{valid: 1'b1, we: we, addr: addr, wdata: wdata, strb: strb, user: '0};
      end else begin
        periph_req = '0;
      end
      @(negedge clk);
    end
    report_test("bridge");
  endtask

  task automatic test_dma_single();
    len_t  len;
    addr_t src;
    addr_t dst;
    user_seen = '0;
    len = len_t'(1 + rand_below(8));
    src = pick_addr(0, 0);
    dst = pick_addr(0, 1);
    dma_setup(0, src, dst, len);
    cfg_write(0, DmaCtrlOff, 64'h1);
    wait_dma_done(0);
    check_copy(0, dst, len);
    check_value(user_seen, 2'b01, "engines seen on memory ports");
    report_test("dma single");
  endtask

  task automatic test_dma_concurrent();
    data_t status;
    addr_t new_src;
    user_seen = '0;
    for (int e = 0; e < NumDsaDma; e++) begin
      dma_setup(e, pick_addr(e, 0), pick_addr(e, 1), len_t'(4 + rand_below(5)));
    end
    cfg_write(0, DmaCtrlOff, 64'h1);
    cfg_write(1, DmaCtrlOff, 64'h1);
    cfg_read(0, DmaStatusOff, status);
    check_value(status, 64'h1, "engine 0 STATUS right after start");
    // Retarget engine 0 and start again while it is still copying
    new_src = reg_src[0] ^ (addr_t'(1) << 30);
    cfg_write(0, DmaSrcOff, data_t'(new_src));
    cfg_write(0, DmaCtrlOff, 64'h1);
    for (int e = 0; e < NumDsaDma; e++) begin
      wait_dma_done(e);
      check_copy(e, reg_dst[e], reg_len[e]);
    end
    reg_src[0] = new_src;
    check_value(user_seen, 2'b11, "engines seen on memory ports");
    report_test("dma concurrent");
  endtask

  task automatic test_cfg_errors();
    reg_off_t off;
    data_t    rd;
    logic     err;
    for (int e = 0; e < NumDsaDma; e++) begin
      off = reg_off_t'(12'h028 + 8 * rand_below(16));
      cfg_access(e, 1'b1, off, rand_word(), rd, err);
      check_value(err, 1, "error flag on unknown offset write");
      check_value(rd, 0, "read data on unknown offset write");
      cfg_access(e, 1'b0, off, '0, rd, err);
      check_value(err, 1, "error flag on unknown offset read");
      check_value(rd, 0, "read data on unknown offset read");
      cfg_read(e, DmaSrcOff, rd);
      check_value(rd, data_t'(reg_src[e]), "SRC after unknown access");
      cfg_read(e, DmaDstOff, rd);
      check_value(rd, data_t'(reg_dst[e]), "DST after unknown access");
      cfg_read(e, DmaLenOff, rd);
      check_value(rd, data_t'(reg_len[e]), "LEN after unknown access");
    end
    report_test("config errors");
  endtask

  initial begin
    rst        = 1'b1;
    rtc        = 1'b0;
    periph_req = '0;
    cfg_req    = '0;
    repeat (4) @(negedge clk);
    rst = 1'b0;
    @(negedge clk);
    test_reset();
    test_timer();
    test_bridge();
    test_dma_single();
    test_dma_concurrent();
    test_cfg_errors();
    $display("Checks: %0d, mismatches: %0d", checks, errors);
    if (errors == 0) begin
      $display("No errors");
    end else begin
      $display("Errors found");
    end
    $finish;
  end

endmodule

// File: testbench/ext_playground_props.sv
/*
 * Playground port properties
 * Response timing on the slave ports, one outstanding DMA memory request
 * per engine, and quiet outputs while reset is held.
 */
`timescale 1ns/1ps

module ext_playground_props (
  input logic                          clk_i,
  input logic                          reset_i,
  input playground_bus_pkg::wide_req_t periph_req_i,
  input playground_bus_pkg::wide_rsp_t periph_rsp_o,
  input playground_bus_pkg::wide_req_t [playground_cfg_pkg::NumDsaDma-1:0] dma_cfg_req_i,
  input playground_bus_pkg::wide_rsp_t [playground_cfg_pkg::NumDsaDma-1:0] dma_cfg_rsp_o,
  input playground_bus_pkg::wide_req_t [playground_cfg_pkg::NumDsaDma-1:0] dma_mem_req_o,
  input playground_bus_pkg::wide_rsp_t [playground_cfg_pkg::NumDsaDma-1:0] dma_mem_rsp_i
);
  import playground_cfg_pkg::*;

  // Set from the second clock of reset on
  logic in_reset_q;

  always_ff @(posedge clk_i) begin
    in_reset_q <= reset_i;
  end

  periph_rsp_timing: assert property (@(posedge clk_i) disable iff (reset_i)
    periph_req_i.valid |-> ##2 periph_rsp_o.valid)
    else $error("peripheral response missing two cycles after a request");

  periph_rsp_origin: assert property (@(posedge clk_i) disable iff (reset_i)
    periph_rsp_o.valid |-> $past(periph_req_i.valid, 2))
    else $error("peripheral response without a request two cycles before");

  periph_quiet_in_reset: assert property (@(posedge clk_i)
    (reset_i && in_reset_q) |-> !periph_rsp_o.valid)
    else $error("peripheral response valid during reset");

  for (genvar i = 0; i < NumDsaDma; i++) begin : gen_engine
    logic outstanding_q;

    always_ff @(posedge clk_i) begin
      if (reset_i) begin
        outstanding_q <= 1'b0;
      end else if (dma_mem_req_o[i].valid) begin
        outstanding_q <= 1'b1;
      end else if (dma_mem_rsp_i[i].valid) begin
        outstanding_q <= 1'b0;
      end
    end

    cfg_rsp_timing: assert property (@(posedge clk_i) disable iff (reset_i)
      dma_cfg_req_i[i].valid |=> dma_cfg_rsp_o[i].valid)
      else $error("config response missing one cycle after a request");

    single_outstanding: assert property (@(posedge clk_i) disable iff (reset_i)
      dma_mem_req_o[i].valid |-> !outstanding_q)
      else $error("DMA memory request issued while another is outstanding");

    dma_quiet_in_reset: assert property (@(posedge clk_i)
      (reset_i && in_reset_q) |-> !dma_mem_req_o[i].valid && !dma_cfg_rsp_o[i].valid)
      else $error("DMA valid raised during reset");
  end

endmodule

bind ext_playground ext_playground_props props_i (
  .clk_i,
  .reset_i,
  .periph_req_i,
  .periph_rsp_o,
  .dma_cfg_req_i,
  .dma_cfg_rsp_o,
  .dma_mem_req_o,
  .dma_mem_rsp_i
);

// File: rtl/ext_playground.sv
/*
 * Accelerator playground top level
 * Peripheral path with the system timer, plus the DMA engines with their
 * configuration and memory ports. Tags DMA memory traffic by engine.
 */
`timescale 1ns/1ps

module ext_playground (
  input  logic                          clk_i,
  input  logic                          reset_i,
  input  logic                          rtc_i,
  // Peripheral slave port
  input  playground_bus_pkg::wide_req_t periph_req_i,
  output playground_bus_pkg::wide_rsp_t periph_rsp_o,
  // DMA configuration slave ports
  input  playground_bus_pkg::wide_req_t [playground_cfg_pkg::NumDsaDma-1:0] dma_cfg_req_i,
  output playground_bus_pkg::wide_rsp_t [playground_cfg_pkg::NumDsaDma-1:0] dma_cfg_rsp_o,
  // DMA memory master ports
  output playground_bus_pkg::wide_req_t [playground_cfg_pkg::NumDsaDma-1:0] dma_mem_req_o,
  input  playground_bus_pkg::wide_rsp_t [playground_cfg_pkg::NumDsaDma-1:0] dma_mem_rsp_i
);
  import playground_bus_pkg::*;
  import playground_cfg_pkg::*;

  //////////////////////////////////////////////////
  // Peripheral path
  //////////////////////////////////////////////////

  nar_req_t timer_req;
  nar_rsp_t timer_rsp;

  periph_bridge i_periph_bridge (
    .clk_i,
    .reset_i,
    .wide_req_i ( periph_req_i ),
    .wide_rsp_o ( periph_rsp_o ),
    .nar_req_o  ( timer_req    ),
    .nar_rsp_i  ( timer_rsp    )
  );

  system_timer i_system_timer (
    .clk_i,
    .reset_i,
    .rtc_i,
    .nar_req_i ( timer_req ),
    .nar_rsp_o ( timer_rsp )
  );

  //////////////////////////////////////////////////
  // DMA engines
  //////////////////////////////////////////////////

  for (genvar i = 0; i < NumDsaDma; i++) begin : gen_dsa_dmas
    dma_cfg_t  dma_cfg;
    logic      dma_start;
    logic      dma_busy;
    logic      dma_done;
    wide_req_t mover_req;

    dma_regs i_dma_regs (
      .clk_i,
      .reset_i,
      .cfg_req_i ( dma_cfg_req_i[i] ),
      .cfg_rsp_o ( dma_cfg_rsp_o[i] ),
      .cfg_o     ( dma_cfg          ),
      .start_o   ( dma_start        ),
      .busy_i    ( dma_busy         ),
      .done_i    ( dma_done         )
    );

    dma_mover i_dma_mover (
      .clk_i,
      .reset_i,
      .cfg_i     ( dma_cfg          ),
      .start_i   ( dma_start        ),
      .mem_req_o ( mover_req        ),
      .mem_rsp_i ( dma_mem_rsp_i[i] ),
      .busy_o    ( dma_busy         ),
      .done_o    ( dma_done         )
    );

    // Engine index goes out as the source tag
    assign dma_mem_req_o[i] = '{
      valid: mover_req.valid,
      we:    mover_req.we,
      addr:  mover_req.addr,
      wdata: mover_req.wdata,
      strb:  mover_req.strb,
      user:  user_t'(i)
    };
  end

endmodule

// File: dma/dma_mover.sv
/*
 * DMA data mover
 * Copies len 64-bit words from src to dst, one memory request at a time.
 */
`timescale 1ns/1ps

module dma_mover (
  input  logic                           clk_i,
  input  logic                           reset_i,
  input  playground_cfg_pkg::dma_cfg_t   cfg_i,
  input  logic                           start_i,
  output playground_bus_pkg::wide_req_t  mem_req_o,
  input  playground_bus_pkg::wide_rsp_t  mem_rsp_i,
  output logic                           busy_o,
  output logic                           done_o
);
  import playground_bus_pkg::*;
  import playground_cfg_pkg::*;

  typedef enum logic [2:0] {
    IDLE,
    READ,
    READ_WAIT,
    WRITE,
    WRITE_WAIT
  } state_e;

  state_e   state_q;
  dma_cfg_t cfg_q;
  len_t     idx_q;
  data_t    data_q;
  logic     done_q;
  addr_t    word_off;
  logic     write_phase;

  assign word_off    = addr_t'({idx_q, 3'b000});
  assign write_phase = (state_q == WRITE) || (state_q == WRITE_WAIT);

  //////////////////////////////////////////////////
  // Control FSM
  //////////////////////////////////////////////////

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      state_q <= IDLE;
      idx_q   <= '0;
      done_q  <= 1'b0;
    end else begin
      done_q <= 1'b0;
      unique case (state_q)
        IDLE: begin
          if (start_i) begin
            idx_q <= '0;
            // Empty job finishes right away
            if (cfg_i.len == '0) begin
              done_q <= 1'b1;
            end else begin
              state_q <= READ;
            end
          end
        end
        READ:      state_q <= READ_WAIT;
        READ_WAIT: begin
          if (mem_rsp_i.valid) begin
            state_q <= WRITE;
          end
        end
        WRITE:     state_q <= WRITE_WAIT;
        WRITE_WAIT: begin
          if (mem_rsp_i.valid) begin
            if (idx_q + len_t'(1) == cfg_q.len) begin
              state_q <= IDLE;
              done_q  <= 1'b1;
            end else begin
              idx_q   <= idx_q + len_t'(1);
              state_q <= READ;
            end
          end
        end
        default:   state_q <= IDLE;
      endcase
    end
  end

  // Job descriptor and word buffer
  always_ff @(posedge clk_i) begin
    if (state_q == IDLE && start_i) begin
      cfg_q <= cfg_i;
    end
    if (state_q == READ_WAIT && mem_rsp_i.valid) begin
      data_q <= mem_rsp_i.rdata;
    end
  end

  always_comb begin
    mem_req_o       = '0;
    mem_req_o.valid = (state_q == READ) || (state_q == WRITE);
    mem_req_o.we    = write_phase;
    mem_req_o.addr  = write_phase ? cfg_q.dst + word_off : cfg_q.src + word_off;
    mem_req_o.wdata = data_q;
    mem_req_o.strb  = '1;
  end

  assign busy_o = (state_q != IDLE);
  assign done_o = done_q;

endmodule

// File: dma/dma_regs.sv
/*
 * DMA register file
 * Source, destination and length registers, start generation and a
 * sticky done flag. Answers every access one cycle later.
 */
`timescale 1ns/1ps

module dma_regs (
  input  logic                           clk_i,
  input  logic                           reset_i,
  input  playground_bus_pkg::wide_req_t  cfg_req_i,
  output playground_bus_pkg::wide_rsp_t  cfg_rsp_o,
  output playground_cfg_pkg::dma_cfg_t   cfg_o,
  output logic                           start_o,
  input  logic                           busy_i,
  input  logic                           done_i
);
  import playground_bus_pkg::*;
  import playground_cfg_pkg::*;

  addr_t    src_q;
  addr_t    dst_q;
  len_t     len_q;
  logic     start_q;
  logic     done_q;
  reg_off_t off;
  logic     wr;
  logic     known;
  logic     start_d;
  data_t    rdata;
  logic     rsp_valid_q;
  data_t    rsp_rdata_q;
  logic     rsp_err_q;

  function automatic data_t masked_write(data_t cur, data_t wdata, strb_t strb);
    data_t res;
    res = cur;
    for (int b = 0; b < StrbWidth; b++) begin
      if (strb[b]) begin
        res[8*b +: 8] = wdata[8*b +: 8];
      end
    end
    return res;
  endfunction

  assign off   = cfg_req_i.addr[RegOffWidth-1:0];
  assign wr    = cfg_req_i.valid && cfg_req_i.we;
  assign known = off inside {DmaSrcOff, DmaDstOff, DmaLenOff, DmaCtrlOff, DmaStatusOff};

  // Start only from an idle engine with no start in flight
  assign start_d = wr && (off == DmaCtrlOff) && cfg_req_i.strb[0] && cfg_req_i.wdata[0] &&
                   !busy_i && !start_q;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      src_q   <= '0;
      dst_q   <= '0;
      len_q   <= '0;
      start_q <= 1'b0;
      done_q  <= 1'b0;
    end else begin
      start_q <= start_d;
      if (wr && off == DmaSrcOff) begin
        src_q <= addr_t'(masked_write(data_t'(src_q), cfg_req_i.wdata, cfg_req_i.strb));
      end
      if (wr && off == DmaDstOff) begin
        dst_q <= addr_t'(masked_write(data_t'(dst_q), cfg_req_i.wdata, cfg_req_i.strb));
      end
      if (wr && off == DmaLenOff) begin
        len_q <= len_t'(masked_write(data_t'(len_q), cfg_req_i.wdata, cfg_req_i.strb));
      end
      if (done_i) begin
        done_q <= 1'b1;
      end else if (start_q) begin
        done_q <= 1'b0;
      end
    end
  end

  always_comb begin
    unique case (off)
      DmaSrcOff:    rdata = data_t'(src_q);
      DmaDstOff:    rdata = data_t'(dst_q);
      DmaLenOff:    rdata = data_t'(len_q);
      DmaStatusOff: rdata = {62'h0, done_q, busy_i};
      default:      rdata = '0;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      rsp_valid_q <= 1'b0;
    end else begin
      rsp_valid_q <= cfg_req_i.valid;
    end
  end

  always_ff @(posedge clk_i) begin
    rsp_err_q   <= !known;
    rsp_rdata_q <= (known && !cfg_req_i.we) ? rdata : '0;
  end

  assign cfg_rsp_o = '{valid: rsp_valid_q, rdata: rsp_rdata_q, err: rsp_err_q};
  assign cfg_o     = '{src: src_q, dst: dst_q, len: len_q};
  assign start_o   = start_q;

endmodule

// File: system_timer/system_timer.sv
/*
 * System timer
 * Free-running 64-bit counter advanced on rising RTC edges while enabled.
 */
`timescale 1ns/1ps

module system_timer (
  input  logic                          clk_i,
  input  logic                          reset_i,
  input  logic                          rtc_i,
  input  playground_bus_pkg::nar_req_t  nar_req_i,
  output playground_bus_pkg::nar_rsp_t  nar_rsp_o
);
  import playground_bus_pkg::*;
  import playground_cfg_pkg::*;

  logic [1:0]  rtc_sync_q;
  logic        rtc_prev_q;
  logic        rtc_edge;
  logic        enable_q;
  logic [63:0] count_q;
  reg_off_t    off;
  logic        wr_ctrl;

  // Two-flop synchronizer plus edge flop
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      rtc_sync_q <= 2'b00;
      rtc_prev_q <= 1'b0;
    end else begin
      rtc_sync_q <= {rtc_sync_q[0], rtc_i};
      rtc_prev_q <= rtc_sync_q[1];
    end
  end

  assign rtc_edge = rtc_sync_q[1] & ~rtc_prev_q;

  assign off     = nar_req_i.addr[RegOffWidth-1:0];
  assign wr_ctrl = nar_req_i.sel && nar_req_i.we && (off == TimerCtrlOff) && nar_req_i.strb[0];

  // Clear wins over a coincident edge
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      enable_q <= 1'b0;
      count_q  <= '0;
    end else begin
      if (wr_ctrl) begin
        enable_q <= nar_req_i.wdata[0];
      end
      if (wr_ctrl && nar_req_i.wdata[1]) begin
        count_q <= '0;
      end else if (enable_q && rtc_edge) begin
        count_q <= count_q + 64'd1;
      end
    end
  end

  // Read mux, answered in the cycle of the request
  always_comb begin
    nar_rsp_o = '0;
    if (nar_req_i.sel) begin
      unique case (off)
        TimerCtrlOff:  nar_rsp_o.rdata = {31'h0, enable_q};
        TimerCntLoOff: nar_rsp_o.rdata = count_q[31:0];
        TimerCntHiOff: nar_rsp_o.rdata = count_q[63:32];
        default:       nar_rsp_o.err   = 1'b1;
      endcase
    end
  end

endmodule

// File: rtl/periph_bridge.sv
/*
 * Peripheral bridge
 * Narrows 64-bit/48-bit requests to the 32-bit peripheral port, decodes
 * the timer window and widens the answer. Response after two cycles.
 */
`timescale 1ns/1ps

module periph_bridge (
  input  logic                           clk_i,
  input  logic                           reset_i,
  input  playground_bus_pkg::wide_req_t  wide_req_i,
  output playground_bus_pkg::wide_rsp_t  wide_rsp_o,
  output playground_bus_pkg::nar_req_t   nar_req_o,
  input  playground_bus_pkg::nar_rsp_t   nar_rsp_i
);
  import playground_bus_pkg::*;
  import playground_cfg_pkg::*;

  nar_addr_t req_addr;
  logic      req_hit;

  // Stage 1 state
  logic      s1_valid_q;
  logic      s1_hit_q;
  logic      s1_lane_q;
  logic      s1_we_q;
  nar_addr_t s1_addr_q;
  nar_data_t s1_wdata_q;
  nar_strb_t s1_strb_q;

  // Stage 2 state
  logic      rsp_valid_q;
  data_t     rsp_rdata_q;
  logic      rsp_err_q;
  nar_data_t rsp_nar_data;
  logic      rsp_err;

  //////////////////////////////////////////////////
  // Stage 1: lane select, truncate, decode
  //////////////////////////////////////////////////

  assign req_addr = wide_req_i.addr[NarAddrWidth-1:0];
  assign req_hit  = (req_addr >= TimerBase) && (req_addr < TimerEnd);

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      s1_valid_q <= 1'b0;
    end else begin
      s1_valid_q <= wide_req_i.valid;
    end
  end

  always_ff @(posedge clk_i) begin
    s1_hit_q   <= req_hit;
    s1_lane_q  <= wide_req_i.addr[2];
    s1_we_q    <= wide_req_i.we;
    s1_addr_q  <= req_addr;
    s1_wdata_q <= wide_req_i.addr[2] ? wide_req_i.wdata[63:32] : wide_req_i.wdata[31:0];
    s1_strb_q  <= wide_req_i.addr[2] ? wide_req_i.strb[7:4] : wide_req_i.strb[3:0];
  end

  assign nar_req_o = '{
    sel:   s1_valid_q & s1_hit_q,
    we:    s1_we_q,
    addr:  s1_addr_q,
    wdata: s1_wdata_q,
    strb:  s1_strb_q
  };

  //////////////////////////////////////////////////
  // Stage 2: merge decode miss, widen
  //////////////////////////////////////////////////

  assign rsp_err      = s1_hit_q ? nar_rsp_i.err : 1'b1;
  // Only a successful read returns data
  assign rsp_nar_data = (!rsp_err && !s1_we_q) ? nar_rsp_i.rdata : '0;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      rsp_valid_q <= 1'b0;
    end else begin
      rsp_valid_q <= s1_valid_q;
    end
  end

  always_ff @(posedge clk_i) begin
    rsp_err_q   <= rsp_err;
    rsp_rdata_q <= s1_lane_q ? {rsp_nar_data, 32'h0} : {32'h0, rsp_nar_data};
  end

  assign wide_rsp_o = '{valid: rsp_valid_q, rdata: rsp_rdata_q, err: rsp_err_q};

endmodule

// File: common/playground_cfg_pkg.sv
/*
 * Playground configuration
 * Address map, register offsets, DMA engine count and DMA job descriptor.
 */
package playground_cfg_pkg;

  localparam int unsigned NumDsaDma = 2;

  // Register offsets live in the low 12 bits of each window
  localparam int unsigned RegOffWidth = 12;
  typedef logic [RegOffWidth-1:0] reg_off_t;

  // Timer window, 4 KiB aligned, end exclusive
  localparam playground_bus_pkg::nar_addr_t TimerBase = 32'h0200_4000;
  localparam playground_bus_pkg::nar_addr_t TimerEnd  = 32'h0200_5000;

  localparam reg_off_t TimerCtrlOff  = 12'h000;
  localparam reg_off_t TimerCntLoOff = 12'h004;
  localparam reg_off_t TimerCntHiOff = 12'h008;

  localparam reg_off_t DmaSrcOff    = 12'h000;
  localparam reg_off_t DmaDstOff    = 12'h008;
  localparam reg_off_t DmaLenOff    = 12'h010;
  localparam reg_off_t DmaCtrlOff   = 12'h018;
  localparam reg_off_t DmaStatusOff = 12'h020;

  // Copy length counted in 64-bit words
  typedef logic [15:0] len_t;

  typedef struct packed {
    playground_bus_pkg::addr_t src;
    playground_bus_pkg::addr_t dst;
    len_t                      len;
  } dma_cfg_t;

endpackage

// File: common/playground_bus_pkg.sv
/*
 * Playground bus definitions
 * Widths, vector types and request/response structs for the 64-bit
 * slave and master ports and for the narrowed 32-bit peripheral port.
 */
package playground_bus_pkg;

  localparam int unsigned AddrWidth    = 48;
  localparam int unsigned DataWidth    = 64;
  localparam int unsigned StrbWidth    = DataWidth / 8;
  localparam int unsigned NarAddrWidth = 32;
  localparam int unsigned NarDataWidth = 32;
  localparam int unsigned NarStrbWidth = NarDataWidth / 8;
  localparam int unsigned UserWidth    = 4;

  typedef logic [AddrWidth-1:0]    addr_t;
  typedef logic [DataWidth-1:0]    data_t;
  typedef logic [StrbWidth-1:0]    strb_t;
  typedef logic [NarAddrWidth-1:0] nar_addr_t;
  typedef logic [NarDataWidth-1:0] nar_data_t;
  typedef logic [NarStrbWidth-1:0] nar_strb_t;
  typedef logic [UserWidth-1:0]    user_t;

  // Wide port, one-cycle request strobe
  typedef struct packed {
    logic  valid;
    logic  we;
    addr_t addr;
    data_t wdata;
    strb_t strb;
    user_t user;
  } wide_req_t;

  typedef struct packed {
    logic  valid;
    data_t rdata;
    logic  err;
  } wide_rsp_t;

  // Narrow peripheral port
  typedef struct packed {
    logic      sel;
    logic      we;
    nar_addr_t addr;
    nar_data_t wdata;
    nar_strb_t strb;
  } nar_req_t;

  typedef struct packed {
    nar_data_t rdata;
    logic      err;
  } nar_rsp_t;

endpackage
